//--- hw/gb_io_pkg.sv
/* Shared definitions of the timer and interrupt I/O block:
   register addresses, bus and interrupt types, TAC rate select */
package gb_io_pkg;

    // Bus and register widths
    typedef logic [15:0] io_addr_t;
    typedef logic [7:0]  io_data_t;

    // Bit 0 vblank, 1 LCD status, 2 timer, 3 serial, 4 joypad
    typedef logic [4:0]  irq_mask_t;

    // Low byte of the interrupt vector
    typedef logic [7:0]  irq_vector_t;

    // Memory-mapped register addresses
    localparam io_addr_t ADDR_DIV  = 16'hFF04;
    localparam io_addr_t ADDR_TIMA = 16'hFF05;
    localparam io_addr_t ADDR_TMA  = 16'hFF06;
    localparam io_addr_t ADDR_TAC  = 16'hFF07;
    localparam io_addr_t ADDR_IF   = 16'hFF0F;
    localparam io_addr_t ADDR_IE   = 16'hFFFF;

    localparam int IRQ_TIMER_BIT = 2;

    // Vector of bit 0, each higher bit adds 8
    localparam irq_vector_t IRQ_VECTOR_BASE = 8'h40;
    localparam irq_vector_t IRQ_VECTOR_NONE = 8'h00;

    // Width of the divider bits below the visible DIV byte
    localparam int DIV_LOW_BITS_DEFAULT = 8;

    // TAC bits 1:0
    typedef enum logic [1:0] {
        RATE_1024 = 2'b00,
        RATE_16   = 2'b01,
        RATE_64   = 2'b10,
        RATE_256  = 2'b11
    } tac_rate_e;

    // Prescaler bit whose falling edge clocks TIMA
    function automatic int unsigned rate_bit(input tac_rate_e rate);
        case (rate)
            RATE_16:  rate_bit = 3;
            RATE_64:  rate_bit = 5;
            RATE_256: rate_bit = 7;
            default:  rate_bit = 9;
        endcase
    endfunction

endpackage

//--- hw/gb_timer.sv
/* Timer block: free-running divider, TAC-gated prescaler and
   TIMA counter with TMA reload and a one-cycle overflow pulse */
module gb_timer #(
    parameter int DIV_LOW_BITS = gb_io_pkg::DIV_LOW_BITS_DEFAULT
) (
    input  logic                I_CLOCK,
    input  logic                I_RESET,
    input  gb_io_pkg::io_data_t wdata,
    input  logic                div_wr,
    input  logic                tima_wr,
    input  logic                tma_wr,
    input  logic                tac_wr,
    output gb_io_pkg::io_data_t div,
    output gb_io_pkg::io_data_t tima,
    output gb_io_pkg::io_data_t tma,
    output gb_io_pkg::io_data_t tac,
    output logic                timer_overflow
);

    localparam int DIVIDER_WIDTH = DIV_LOW_BITS + 8;

    // Divider with DIV as its top byte
    logic [DIVIDER_WIDTH-1:0] divider;

    // Prescaler for TIMA, runs only while the timer is enabled
    logic [9:0] prescaler;

    logic [2:0]          tac_q;
    gb_io_pkg::io_data_t tma_q;
    gb_io_pkg::io_data_t tima_q;

    gb_io_pkg::tac_rate_e rate;
    logic                 timer_en;
    logic                 sel_bit;
    logic                 sel_bit_q;
    logic                 tick;
    gb_io_pkg::io_data_t  reload_value;

    assign rate     = gb_io_pkg::tac_rate_e'(tac_q[1:0]);
    assign timer_en = tac_q[2];

    always_ff @(posedge I_CLOCK or posedge I_RESET) begin
        if (I_RESET) begin
            divider <= '0;
        end else if (div_wr) begin
            divider <= '0;
        end else begin
            divider <= divider + 1'b1;
        end
    end

    always_ff @(posedge I_CLOCK or posedge I_RESET) begin
        if (I_RESET) begin
            prescaler <= '0;
        end else if (timer_en) begin
            prescaler <= prescaler + 1'b1;
        end
    end

    // TAC and TMA are plain write registers
    always_ff @(posedge I_CLOCK or posedge I_RESET) begin
        if (I_RESET) begin
            tac_q <= '0;
        end else if (tac_wr) begin
            tac_q <= wdata[2:0];
        end
    end

    always_ff @(posedge I_CLOCK or posedge I_RESET) begin
        if (I_RESET) begin
            tma_q <= '0;
        end else if (tma_wr) begin
            tma_q <= wdata;
        end
    end

    // Falling edge of the selected prescaler bit
    assign sel_bit = prescaler[gb_io_pkg::rate_bit(rate)];

    always_ff @(posedge I_CLOCK or posedge I_RESET) begin
        if (I_RESET) begin
            sel_bit_q <= 1'b0;
        end else begin
            sel_bit_q <= sel_bit;
        end
    end

    assign tick = sel_bit_q & ~sel_bit & timer_en;

    // A TMA write in the overflow cycle reloads the new value
    assign reload_value = tma_wr ? wdata : tma_q;

    // No overflow when the CPU writes TIMA in the same cycle
    assign timer_overflow = tick & (tima_q == 8'hFF) & ~tima_wr;

    always_ff @(posedge I_CLOCK or posedge I_RESET) begin
        if (I_RESET) begin
            tima_q <= '0;
        end else if (tima_wr) begin
            tima_q <= wdata;
        end else if (tick) begin
            if (tima_q == 8'hFF) begin
                tima_q <= reload_value;
            end else begin
                tima_q <= tima_q + 8'd1;
            end
        end
    end

    assign div  = divider[DIV_LOW_BITS +: 8];
    assign tima = tima_q;
    assign tma  = tma_q;

    // Upper TAC bits are padded by the bus
    assign tac  = {5'b00000, tac_q};

endmodule

//--- hw/gb_interrupt_ctrl.sv
/* Interrupt controller: IF and IE registers, request capture
   and lowest-bit-first priority encoding into the CPU vector */
module gb_interrupt_ctrl (
    input  logic                   I_CLOCK,
    input  logic                   I_RESET,
    input  gb_io_pkg::io_data_t    wdata,
    input  logic                   if_wr,
    input  logic                   ie_wr,
    input  gb_io_pkg::irq_mask_t   ext_irq,
    input  logic                   timer_overflow,
    output gb_io_pkg::io_data_t    if_reg,
    output gb_io_pkg::io_data_t    ie_reg,
    output logic                   irq_pending,
    output gb_io_pkg::irq_vector_t irq_vector
);

    gb_io_pkg::irq_mask_t   if_q;
    gb_io_pkg::irq_mask_t   ie_q;
    gb_io_pkg::irq_mask_t   request;
    gb_io_pkg::irq_mask_t   active;
    gb_io_pkg::irq_vector_t vector;

    // Timer owns its bit, the external line there is dropped
    always_comb begin
        request = ext_irq;
        request[gb_io_pkg::IRQ_TIMER_BIT] = timer_overflow;
    end

    // Written bits replace old flags, new requests always land
    always_ff @(posedge I_CLOCK or posedge I_RESET) begin
        if (I_RESET) begin
            if_q <= '0;
        end else if (if_wr) begin
            if_q <= wdata[4:0] | request;
        end else begin
            if_q <= if_q | request;
        end
    end

    always_ff @(posedge I_CLOCK or posedge I_RESET) begin
        if (I_RESET) begin
            ie_q <= '0;
        end else if (ie_wr) begin
            ie_q <= wdata[4:0];
        end
    end

    assign active = if_q & ie_q;

    // Scan from the top so the lowest set bit is the last to win
    always_comb begin
        vector = gb_io_pkg::IRQ_VECTOR_NONE;
        for (int i = 4; i >= 0; i--) begin
            if (active[i]) begin
                vector = gb_io_pkg::IRQ_VECTOR_BASE + 8'(i * 8);
            end
        end
    end

    assign irq_pending = |active;
    assign irq_vector  = vector;

    // Padding of bits 7:5 happens in the bus
    assign if_reg = {3'b000, if_q};
    assign ie_reg = {3'b000, ie_q};

endmodule

//--- hw/gb_io_bus.sv
/* CPU bus front end: decodes register writes and returns
   read data one cycle after the strobe from a registered mux */
module gb_io_bus (
    input  logic                I_CLOCK,
    input  logic                I_RESET,
    input  gb_io_pkg::io_addr_t addr,
    input  gb_io_pkg::io_data_t wdata,
    input  logic                read_n,
    input  logic                write_n,
    input  gb_io_pkg::io_data_t div,
    input  gb_io_pkg::io_data_t tima,
    input  gb_io_pkg::io_data_t tma,
    input  gb_io_pkg::io_data_t tac,
    input  gb_io_pkg::io_data_t if_reg,
    input  gb_io_pkg::io_data_t ie_reg,
    output logic                div_wr,
    output logic                tima_wr,
    output logic                tma_wr,
    output logic                tac_wr,
    output logic                if_wr,
    output logic                ie_wr,
    output gb_io_pkg::io_data_t rdata,
    output logic                rdata_valid
);

    // Unused register bits read back as ones
    localparam gb_io_pkg::io_data_t TAC_PAD = 8'hF8;
    localparam gb_io_pkg::io_data_t IRQ_PAD = 8'hE0;

    logic                write_en;
    logic                read_en;
    gb_io_pkg::io_data_t read_mux;

    assign write_en = ~write_n;

    // Write wins when both strobes are low
    assign read_en  = ~read_n & write_n;

    assign div_wr  = write_en & (addr == gb_io_pkg::ADDR_DIV);
    assign tima_wr = write_en & (addr == gb_io_pkg::ADDR_TIMA);
    assign tma_wr  = write_en & (addr == gb_io_pkg::ADDR_TMA);
    assign tac_wr  = write_en & (addr == gb_io_pkg::ADDR_TAC);
    assign if_wr   = write_en & (addr == gb_io_pkg::ADDR_IF);
    assign ie_wr   = write_en & (addr == gb_io_pkg::ADDR_IE);

    always_comb begin
        case (addr)
            gb_io_pkg::ADDR_DIV:  read_mux = div;
            gb_io_pkg::ADDR_TIMA: read_mux = tima;
            gb_io_pkg::ADDR_TMA:  read_mux = tma;
            gb_io_pkg::ADDR_TAC:  read_mux = tac | TAC_PAD;
            gb_io_pkg::ADDR_IF:   read_mux = if_reg | IRQ_PAD;
            gb_io_pkg::ADDR_IE:   read_mux = ie_reg | IRQ_PAD;
            default:              read_mux = 8'hFF;
        endcase
    end

    // Captures the value from before the strobe edge
    always_ff @(posedge I_CLOCK or posedge I_RESET) begin
        if (I_RESET) begin
            rdata       <= '0;
            rdata_valid <= 1'b0;
        end else begin
            rdata_valid <= read_en;
            if (read_en) begin
                rdata <= read_mux;
            end
        end
    end

endmodule

//--- hw/gb_timer_subsystem.sv
/* Timer and interrupt I/O subsystem: bus front end, timer
   and interrupt controller on one CPU register port */
module gb_timer_subsystem #(
    parameter int DIV_LOW_BITS = gb_io_pkg::DIV_LOW_BITS_DEFAULT
) (
    input  logic                   I_CLOCK,
    input  logic                   I_RESET,
    input  gb_io_pkg::io_addr_t    addr,
    input  gb_io_pkg::io_data_t    wdata,
    input  logic                   read_n,
    input  logic                   write_n,
    input  gb_io_pkg::irq_mask_t   ext_irq,
    output gb_io_pkg::io_data_t    rdata,
    output logic                   rdata_valid,
    output logic                   irq_pending,
    output gb_io_pkg::irq_vector_t irq_vector
);

    // Register write pulses
    logic div_wr;
    logic tima_wr;
    logic tma_wr;
    logic tac_wr;
    logic if_wr;
    logic ie_wr;

    // Register values back to the read mux
    gb_io_pkg::io_data_t div;
    gb_io_pkg::io_data_t tima;
    gb_io_pkg::io_data_t tma;
    gb_io_pkg::io_data_t tac;
    gb_io_pkg::io_data_t if_reg;
    gb_io_pkg::io_data_t ie_reg;

    logic timer_overflow;

    gb_io_bus bus0 (
        .I_CLOCK     (I_CLOCK),
        .I_RESET     (I_RESET),
        .addr        (addr),
        .wdata       (wdata),
        .read_n      (read_n),
        .write_n     (write_n),
        .div         (div),
        .tima        (tima),
        .tma         (tma),
        .tac         (tac),
        .if_reg      (if_reg),
        .ie_reg      (ie_reg),
        .div_wr      (div_wr),
        .tima_wr     (tima_wr),
        .tma_wr      (tma_wr),
        .tac_wr      (tac_wr),
        .if_wr       (if_wr),
        .ie_wr       (ie_wr),
        .rdata       (rdata),
        .rdata_valid (rdata_valid)
    );

    gb_timer #(
        .DIV_LOW_BITS (DIV_LOW_BITS)
    ) timer0 (
        .I_CLOCK        (I_CLOCK),
        .I_RESET        (I_RESET),
        .wdata          (wdata),
        .div_wr         (div_wr),
        .tima_wr        (tima_wr),
        .tma_wr         (tma_wr),
        .tac_wr         (tac_wr),
        .div            (div),
        .tima           (tima),
        .tma            (tma),
        .tac            (tac),
        .timer_overflow (timer_overflow)
    );

    gb_interrupt_ctrl irq0 (
        .I_CLOCK        (I_CLOCK),
        .I_RESET        (I_RESET),
        .wdata          (wdata),
        .if_wr          (if_wr),
        .ie_wr          (ie_wr),
        .ext_irq        (ext_irq),
        .timer_overflow (timer_overflow),
        .if_reg         (if_reg),
        .ie_reg         (ie_reg),
        .irq_pending    (irq_pending),
        .irq_vector     (irq_vector)
    );

endmodule

//--- verification/gb_timer_subsystem_sva.sv
/* Bound assertions of the timer subsystem: read data timing,
   overflow pulse width, interrupt outputs and reset values */
module gb_timer_subsystem_sva (
    input logic                   I_CLOCK,
    input logic                   I_RESET,
    input logic                   read_n,
    input logic                   write_n,
    input gb_io_pkg::io_data_t    rdata,
    input logic                   rdata_valid,
    input logic                   irq_pending,
    input gb_io_pkg::irq_vector_t irq_vector,
    input logic                   timer_overflow
);

    timeunit 1ns;
    timeprecision 1ps;

    int   fail_count = 0;
    logic read_strobe;

    // A write on the same edge cancels the read
    assign read_strobe = !read_n && write_n;

    valid_after_read: assert property (@(posedge I_CLOCK) disable iff (I_RESET)
        read_strobe |=> rdata_valid)
    else begin
        fail_count++;
        $error("rdata_valid missing one cycle after a read strobe");
    end

    no_valid_without_read: assert property (@(posedge I_CLOCK) disable iff (I_RESET)
        !read_strobe |=> !rdata_valid)
    else begin
        fail_count++;
        $error("rdata_valid high without a read strobe");
    end

    overflow_single_cycle: assert property (@(posedge I_CLOCK) disable iff (I_RESET)
        timer_overflow |=> !timer_overflow)
    else begin
        fail_count++;
        $error("timer_overflow high for two cycles in a row");
    end

    pending_matches_vector: assert property (@(posedge I_CLOCK) disable iff (I_RESET)
        irq_pending == (irq_vector != 8'h00))
    else begin
        fail_count++;
        $error("irq_pending disagrees with irq_vector");
    end

    // Held reset for two edges leaves every output cleared
    outputs_low_in_reset: assert property (@(posedge I_CLOCK)
        (I_RESET && $past(I_RESET)) |->
        (!rdata_valid && !irq_pending && irq_vector == 8'h00 && rdata == 8'h00))
    else begin
        fail_count++;
        $error("outputs not low during reset");
    end

endmodule

bind gb_timer_subsystem gb_timer_subsystem_sva sva0 (
    .I_CLOCK        (I_CLOCK),
    .I_RESET        (I_RESET),
    .read_n         (read_n),
    .write_n        (write_n),
    .rdata          (rdata),
    .rdata_valid    (rdata_valid),
    .irq_pending    (irq_pending),
    .irq_vector     (irq_vector),
    .timer_overflow (timer_overflow)
);

//--- verification/tb_gb_timer_subsystem.sv
/* Testbench of the timer and interrupt subsystem: LCG-driven bus
   traffic checked against a cycle-exact reference model */
module tb_gb_timer_subsystem;

    timeunit 1ns;
    timeprecision 1ps;

    localparam int DIV_LOW_BITS = 4;
    localparam int WAIT_LIMIT   = 5000;

    logic                   I_CLOCK;
    logic                   I_RESET;
    gb_io_pkg::io_addr_t    addr;
    gb_io_pkg::io_data_t    wdata;
    logic                   read_n;
    logic                   write_n;
    gb_io_pkg::irq_mask_t   ext_irq;
    gb_io_pkg::io_data_t    rdata;
    logic                   rdata_valid;
    logic                   irq_pending;
    gb_io_pkg::irq_vector_t irq_vector;

    // Reference model state
    logic [DIV_LOW_BITS+7:0] m_divider;
    logic [9:0]              m_prescaler;
    logic [2:0]              m_tac;
    gb_io_pkg::io_data_t     m_tma;
    gb_io_pkg::io_data_t     m_tima;
    logic                    m_sel_q;
    gb_io_pkg::irq_mask_t    m_if;
    gb_io_pkg::irq_mask_t    m_ie;
    gb_io_pkg::io_data_t     m_rdata;

    logic [31:0] lcg_state;
    int          errors;
    int          checks;
    int          tests_failed;
    int          errors_before;
    string       test_name;

    gb_timer_subsystem #(
        .DIV_LOW_BITS (DIV_LOW_BITS)
    ) dut0 (
        .I_CLOCK     (I_CLOCK),
        .I_RESET     (I_RESET),
        .addr        (addr),
        .wdata       (wdata),
        .read_n      (read_n),
        .write_n     (write_n),
        .ext_irq     (ext_irq),
        .rdata       (rdata),
        .rdata_valid (rdata_valid),
        .irq_pending (irq_pending),
        .irq_vector  (irq_vector)
    );

    initial begin
        I_CLOCK = 1'b0;
        forever begin
            #4 I_CLOCK = ~I_CLOCK;
        end
    end

    function automatic logic [31:0] lcg_next();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state;
    endfunction

    function automatic logic [7:0] rand_byte();
        logic [31:0] r;
        r = lcg_next();
        return r[23:16];
    endfunction

    // TAC rate select to the prescaler bit that clocks TIMA
    function automatic int rate_to_bit(input logic [1:0] rate);
        case (rate)
            2'b01:   return 3;
            2'b10:   return 5;
            2'b11:   return 7;
            default: return 9;
        endcase
    endfunction

    function automatic logic is_mapped(input gb_io_pkg::io_addr_t a);
        case (a)
            gb_io_pkg::ADDR_DIV, gb_io_pkg::ADDR_TIMA, gb_io_pkg::ADDR_TMA,
            gb_io_pkg::ADDR_TAC, gb_io_pkg::ADDR_IF, gb_io_pkg::ADDR_IE: return 1'b1;
            default: return 1'b0;
        endcase
    endfunction

    // Register view as the CPU sees it with unused bits as ones
    function automatic gb_io_pkg::io_data_t model_read(input gb_io_pkg::io_addr_t a);
        case (a)
            gb_io_pkg::ADDR_DIV:  return m_divider[DIV_LOW_BITS +: 8];
            gb_io_pkg::ADDR_TIMA: return m_tima;
            gb_io_pkg::ADDR_TMA:  return m_tma;
            gb_io_pkg::ADDR_TAC:  return {5'b11111, m_tac};
            gb_io_pkg::ADDR_IF:   return {3'b111, m_if};
            gb_io_pkg::ADDR_IE:   return {3'b111, m_ie};
            default:              return 8'hFF;
        endcase
    endfunction

    // Lowest enabled pending bit picks the vector
    function automatic gb_io_pkg::irq_vector_t model_vector(input gb_io_pkg::irq_mask_t act);
        gb_io_pkg::irq_vector_t v;
        v = 8'h00;
        for (int i = 0; i < 5; i++) begin
            if (act[i] && v == 8'h00) begin
                v = 8'h40 + 8'(8 * i);
            end
        end
        return v;
    endfunction

    always @(posedge I_CLOCK) begin : ref_model
        logic                 wr;
        logic                 rd;
        logic                 sel;
        logic                 tick;
        logic                 ovf;
        gb_io_pkg::irq_mask_t req;
        if (I_RESET) begin
            m_divider   = '0;
            m_prescaler = '0;
            m_tac       = '0;
            m_tma       = '0;
            m_tima      = '0;
            m_sel_q     = 1'b0;
            m_if        = '0;
            m_ie        = '0;
            m_rdata     = '0;
        end else begin
            wr     = !write_n;
            rd     = !read_n && write_n;
            sel    = m_prescaler[rate_to_bit(m_tac[1:0])];
            tick   = m_sel_q && !sel && m_tac[2];
            ovf    = tick && m_tima == 8'hFF && !(wr && addr == gb_io_pkg::ADDR_TIMA);
            req    = ext_irq;
            req[2] = ovf;
            if (rd) begin
                m_rdata = model_read(addr);
            end
            // TIMA first since it reloads from TMA before TMA is written
            if (wr && addr == gb_io_pkg::ADDR_TIMA) begin
                m_tima = wdata;
            end else if (tick) begin
                if (m_tima == 8'hFF) begin
                    m_tima = (wr && addr == gb_io_pkg::ADDR_TMA) ? wdata : m_tma;
                end else begin
                    m_tima = m_tima + 8'd1;
                end
            end
            if (wr && addr == gb_io_pkg::ADDR_TMA) begin
                m_tma = wdata;
            end
            if (m_tac[2]) begin
                m_prescaler = m_prescaler + 10'd1;
            end
            if (wr && addr == gb_io_pkg::ADDR_TAC) begin
                m_tac = wdata[2:0];
            end
            if (wr && addr == gb_io_pkg::ADDR_DIV) begin
                m_divider = '0;
            end else begin
                m_divider = m_divider + 1'b1;
            end
            m_sel_q = sel;
            if (wr && addr == gb_io_pkg::ADDR_IF) begin
                m_if = wdata[4:0] | req;
            end else begin
                m_if = m_if | req;
            end
            if (wr && addr == gb_io_pkg::ADDR_IE) begin
                m_ie = wdata[4:0];
            end
        end
    end

    task automatic check_data(input string what, input gb_io_pkg::io_data_t exp,
                              input gb_io_pkg::io_data_t act);
        checks++;
        if (act !== exp) begin
            errors++;
            $display("mismatch %s %s: expected %h actual %h", test_name, what, exp, act);
        end
    endtask

    task automatic check_vector(input string what, input gb_io_pkg::irq_vector_t exp,
                                input gb_io_pkg::irq_vector_t act);
        checks++;
        if (act !== exp) begin
            errors++;
            $display("mismatch %s %s: expected %h actual %h", test_name, what, exp, act);
        end
    endtask

    task automatic check_pending(input string what, input logic exp, input logic act);
        checks++;
        if (act !== exp) begin
            errors++;
            $display("mismatch %s %s: expected %b actual %b", test_name, what, exp, act);
        end
    endtask

    task automatic bus_write(input gb_io_pkg::io_addr_t a, input gb_io_pkg::io_data_t d);
        @(negedge I_CLOCK);
        addr    = a;
        wdata   = d;
        write_n = 1'b0;
        @(negedge I_CLOCK);
        write_n = 1'b1;
    endtask

    task automatic bus_read(input gb_io_pkg::io_addr_t a, output gb_io_pkg::io_data_t value);
        int waited;
        @(negedge I_CLOCK);
        addr   = a;
        read_n = 1'b0;
        @(negedge I_CLOCK);
        read_n = 1'b1;
        waited = 0;
        while (!rdata_valid && waited < WAIT_LIMIT) begin
            @(negedge I_CLOCK);
            waited++;
        end
        if (!rdata_valid) begin
            errors++;
            $display("%s: rdata_valid never came after a read of %h", test_name, a);
        end
        value = rdata;
    endtask

    task automatic read_vs_model(input string what, input gb_io_pkg::io_addr_t a);
        gb_io_pkg::io_data_t v;
        bus_read(a, v);
        check_data(what, m_rdata, v);
    endtask

    task automatic idle(input int cycles);
        repeat (cycles) @(negedge I_CLOCK);
    endtask

    task automatic begin_test(input string name);
        test_name     = name;
        errors_before = errors;
    endtask

    task automatic end_test();
        if (errors == errors_before) begin
            $display("test %s: ok", test_name);
        end else begin
            tests_failed++;
            $display("test %s: %0d errors", test_name, errors - errors_before);
        end
    endtask

    initial begin
        gb_io_pkg::io_addr_t a;
        gb_io_pkg::io_data_t v;
        gb_io_pkg::io_data_t v2;
        logic [7:0]          r;
        int                  waited;
        int                  sva_failures;
        lcg_state    = 32'd40;
        errors       = 0;
        checks       = 0;
        tests_failed = 0;
        I_RESET      = 1'b1;
        addr         = '0;
        wdata        = '0;
        read_n       = 1'b1;
        write_n      = 1'b1;
        ext_irq      = '0;
        repeat (8) @(posedge I_CLOCK);
        @(negedge I_CLOCK);
        I_RESET = 1'b0;

        begin_test("register_access");
        for (int i = 0; i < 24; i++) begin
            r = rand_byte();
            case (r[1:0])
                2'd0:    a = gb_io_pkg::ADDR_TMA;
                2'd1:    a = gb_io_pkg::ADDR_TAC;
                2'd2:    a = gb_io_pkg::ADDR_IE;
                default: a = gb_io_pkg::ADDR_IF;
            endcase
            bus_write(a, rand_byte());
            read_vs_model("readback", a);
        end
        for (int i = 0; i < 8; i++) begin
            a = {rand_byte(), rand_byte()};
            while (is_mapped(a)) begin
                a = a + 16'd1;
            end
            bus_read(a, v);
            check_data("unmapped", 8'hFF, v);
        end
        end_test();

        // DIV runs with the timer off
        begin_test("div");
        bus_write(gb_io_pkg::ADDR_TAC, 8'h00);
        for (int i = 0; i < 6; i++) begin
            bus_write(gb_io_pkg::ADDR_DIV, rand_byte());
            read_vs_model("after_clear", gb_io_pkg::ADDR_DIV);
            idle(int'(rand_byte()));
            read_vs_model("counting", gb_io_pkg::ADDR_DIV);
        end
        end_test();

        begin_test("tima_rates");
        for (int rate = 0; rate < 4; rate++) begin
            bus_write(gb_io_pkg::ADDR_TAC, 8'(4 + rate));
            bus_write(gb_io_pkg::ADDR_TIMA, rand_byte() >> 1);
            idle(3 * (2 << rate_to_bit(2'(rate))));
            read_vs_model("enabled", gb_io_pkg::ADDR_TIMA);
            idle(int'(rand_byte()));
            read_vs_model("enabled_more", gb_io_pkg::ADDR_TIMA);
        end
        bus_write(gb_io_pkg::ADDR_TAC, rand_byte() & 8'hFB);
        bus_read(gb_io_pkg::ADDR_TIMA, v);
        check_data("disabled", m_rdata, v);
        idle(300);
        bus_read(gb_io_pkg::ADDR_TIMA, v2);
        check_data("held", m_rdata, v2);
        end_test();

        begin_test("overflow");
        bus_write(gb_io_pkg::ADDR_IE, 8'h04);
        for (int i = 0; i < 6; i++) begin
            bus_write(gb_io_pkg::ADDR_TAC, 8'h00);
            bus_write(gb_io_pkg::ADDR_IF, 8'h00);
            bus_write(gb_io_pkg::ADDR_TMA, rand_byte());
            r = rand_byte();
            bus_write(gb_io_pkg::ADDR_TIMA, {6'b111111, r[1:0]});
            bus_write(gb_io_pkg::ADDR_TAC, 8'h05);
            waited = 0;
            while (!irq_pending && waited < WAIT_LIMIT) begin
                @(negedge I_CLOCK);
                waited++;
            end
            if (!irq_pending) begin
                errors++;
                $display("%s: the timer interrupt was never raised", test_name);
            end
            check_pending("pending", |(m_if & m_ie), irq_pending);
            check_vector("vector", model_vector(m_if & m_ie), irq_vector);
            read_vs_model("reload", gb_io_pkg::ADDR_TIMA);
            read_vs_model("if_timer", gb_io_pkg::ADDR_IF);
        end
        end_test();

        begin_test("priority");
        bus_write(gb_io_pkg::ADDR_TAC, 8'h00);
        bus_write(gb_io_pkg::ADDR_IF, 8'h00);
        for (int i = 0; i < 40; i++) begin
            bus_write(gb_io_pkg::ADDR_IE, rand_byte());
            @(negedge I_CLOCK);
            r       = rand_byte();
            ext_irq = r[4:0];
            @(negedge I_CLOCK);
            ext_irq = '0;
            check_pending("pending", |(m_if & m_ie), irq_pending);
            check_vector("vector", model_vector(m_if & m_ie), irq_vector);
            bus_write(gb_io_pkg::ADDR_IF, 8'h00);
            check_pending("cleared", 1'b0, irq_pending);
        end
        end_test();

        sva_failures = dut0.sva0.fail_count;
        errors       = errors + sva_failures;
        $display("5 tests, %0d failed, %0d checks, %0d errors, %0d assertion failures",
                 tests_failed, checks, errors, sva_failures);
        if (errors == 0) begin
            $display("** PASS **");
        end else begin
            $display("** FAIL **");
        end
        $finish;
    end

endmodule

//--- build.f
hw/gb_io_pkg.sv
hw/gb_timer.sv
hw/gb_interrupt_ctrl.sv
hw/gb_io_bus.sv
hw/gb_timer_subsystem.sv
verification/gb_timer_subsystem_sva.sv
verification/tb_gb_timer_subsystem.sv

//--- run_sim.sh
#!/usr/bin/env bash
# Builds the timer subsystem testbench with Verilator and runs it

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal --timescale 1ns/1ps \
    --top-module tb_gb_timer_subsystem -f build.f -o sim_tb \
    || { echo "verilator build failed"; exit 1; }

# Keep going after an assertion error so the testbench prints its verdict
sim_output=$(./obj_dir/sim_tb +verilator+error+limit+100)
echo "$sim_output"

echo "$sim_output" | grep -qxF '** PASS **' && exit 0 || exit 1
